// File: design/debugCmdPkg.sv
package debugCmdPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Controller states
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      INIT       = 3'd0,   // One cycle after reset
      IDLE       = 3'd1,   // Waiting for c or s
      CONTINUOUS = 3'd2,   // Free running until end of program
      STEP       = 3'd3,   // Waiting for n
      SEND       = 3'd4    // Frame going out through the UART
   } debugState;

   ////////////////////////////////////////////////////////////////////////////
   // Command characters from the host
   ////////////////////////////////////////////////////////////////////////////

   // ASCII codes, one byte each
   typedef enum logic [7:0] {
      CmdContinuous = 8'h63,   // "c"
      CmdStep       = 8'h73,   // "s"
      CmdNext       = 8'h6E    // "n"
   } debugCmd;

endpackage

// File: design/dumpFramePkg.sv
package dumpFramePkg;

   ////////////////////////////////////////////////////////////////////////////
   // Frame data types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [7:0]  dumpByte;   // Frame byte or command byte
   typedef logic [31:0] dumpWord;   // Processor word

   // Where a frame byte comes from
   typedef enum logic [1:0] {
      SegPc    = 2'd0,
      SegInstr = 2'd1,
      SegReg   = 2'd2,
      SegMem   = 2'd3
   } dumpSegment;

   localparam int WordBytes   = 4;
   localparam int HeaderBytes = 5;   // PC byte plus the IF/ID instruction

   ////////////////////////////////////////////////////////////////////////////
   // Layout helpers
   ////////////////////////////////////////////////////////////////////////////

   // Total bytes in one dump
   function automatic int frameBytes(input int numRegs, input int numMemWords);
      return HeaderBytes + WordBytes * (numRegs + numMemWords);
   endfunction

   // Lane 0 is the most significant byte, sent first
   function automatic dumpByte wordByte(input dumpWord word, input logic [1:0] lane);
      dumpByte result;
      case (lane)
         2'd0:    result = word[31:24];
         2'd1:    result = word[23:16];
         2'd2:    result = word[15:8];
         default: result = word[7:0];
      endcase
      return result;
   endfunction

endpackage

// File: design/debugCommandFsm.sv
`timescale 1ns/1ps

module debugCommandFsm (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  endOfProgram,
   input  dumpFramePkg::dumpByte uartFifoDataIn,
   input  logic                  uartDataAvailable,
   input  logic                  dumpDone,
   output logic                  nextFifoValue,     // Pop strobe to the RX FIFO
   output logic                  datapathOn,        // Clock enable for the pipeline
   output logic                  datapathReset,     // Holds the pipeline flushed
   output logic                  ledIdle,
   output logic                  dumpActive         // High while a frame is sent
);

   debugCmdPkg::debugState state;
   debugCmdPkg::debugState nextState;
   debugCmdPkg::debugCmd   cmd;
   logic                   continuousUsed;   // Continuous mode runs once per reset

   assign cmd = debugCmdPkg::debugCmd'(uartFifoDataIn);

   ////////////////////////////////////////////////////////////////////////////
   // State register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state          <= debugCmdPkg::INIT;
         continuousUsed <= 1'b0;
      end else begin
         state <= nextState;
         if (state == debugCmdPkg::CONTINUOUS) begin
            continuousUsed <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Next state and outputs
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      nextState     = state;
      nextFifoValue = 1'b0;
      datapathOn    = 1'b0;
      datapathReset = 1'b0;
      ledIdle       = 1'b0;
      dumpActive    = 1'b0;

      case (state)
         debugCmdPkg::INIT: begin
            datapathReset = 1'b1;
            nextState     = debugCmdPkg::IDLE;
         end

         debugCmdPkg::IDLE: begin
            ledIdle       = 1'b1;
            datapathReset = 1'b1;
            nextFifoValue = uartDataAvailable;   // Every byte is consumed
            if (uartDataAvailable) begin
               if (cmd == debugCmdPkg::CmdContinuous && !continuousUsed) begin
                  nextState = debugCmdPkg::CONTINUOUS;
               end else if (cmd == debugCmdPkg::CmdStep) begin
                  nextState = debugCmdPkg::STEP;
               end
            end
         end

         debugCmdPkg::CONTINUOUS: begin
            datapathOn = 1'b1;
            if (endOfProgram) begin
               nextState = debugCmdPkg::SEND;
            end
         end

         debugCmdPkg::STEP: begin
            nextFifoValue = uartDataAvailable;
            // One clock of the datapath, then dump
            if (uartDataAvailable && cmd == debugCmdPkg::CmdNext) begin
               datapathOn = 1'b1;
               nextState  = debugCmdPkg::SEND;
            end
         end

         debugCmdPkg::SEND: begin
            dumpActive = 1'b1;
            if (dumpDone) begin
               // Finished program goes back to idle
               nextState = endOfProgram ? debugCmdPkg::IDLE : debugCmdPkg::STEP;
            end
         end

         default: begin
            nextState = debugCmdPkg::INIT;
         end
      endcase
   end

endmodule

// File: design/dumpSequencer.sv
`timescale 1ns/1ps

module dumpSequencer #(
   parameter int NumRegs     = 32,
   parameter int NumMemWords = 16
) (
   input  logic       clock,
   input  logic       reset,
   input  logic       dumpActive,
   input  logic       uartDataSent,        // One pulse per byte on the wire
   output logic [7:0] byteIndex,
   output logic       notStartUartTrans,   // Low lets the transmitter run
   output logic       dumpDone
);

   localparam int         FrameLen = dumpFramePkg::frameBytes(NumRegs, NumMemWords);
   localparam logic [7:0] FrameEnd = 8'(FrameLen);

   logic bytesLeft;

   assign bytesLeft = byteIndex < FrameEnd;

   ////////////////////////////////////////////////////////////////////////////
   // Byte counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         byteIndex <= '0;
      end else if (!dumpActive) begin
         byteIndex <= '0;                      // Next frame starts at byte 0
      end else if (uartDataSent && bytesLeft) begin
         byteIndex <= byteIndex + 8'd1;
      end
   end

   // Transmitter stays enabled while bytes remain
   assign notStartUartTrans = !(dumpActive && bytesLeft);

   // Index sits at the frame end for one cycle before the FSM leaves SEND
   assign dumpDone = dumpActive && !bytesLeft;

endmodule

// File: design/dumpFrameMux.sv
`timescale 1ns/1ps

module dumpFrameMux #(
   parameter int NumRegs     = 32,
   parameter int NumMemWords = 16
) (
   input  logic [7:0]            byteIndex,
   input  logic [7:0]            fetchPc,
   input  dumpFramePkg::dumpWord ifIdInstr,
   input  dumpFramePkg::dumpWord regData,         // Answers debugRegAddr
   input  dumpFramePkg::dumpWord memoryRamData,   // Answers debugMemAddr
   output logic [7:0]            debugRegAddr,
   output logic [7:0]            debugMemAddr,
   output dumpFramePkg::dumpByte dataToSend
);

   localparam int RegAddrWidth = $clog2(NumRegs);
   localparam int MemAddrWidth = $clog2(NumMemWords);

   // First byte of each word segment
   localparam logic [7:0] RegBase = 8'(dumpFramePkg::HeaderBytes);
   localparam logic [7:0] MemBase =
      8'(dumpFramePkg::HeaderBytes + dumpFramePkg::WordBytes * NumRegs);

   dumpFramePkg::dumpSegment segment;
   logic [7:0]               instrOffset;
   logic [7:0]               regOffset;
   logic [7:0]               memOffset;
   logic [7:0]               regWord;
   logic [7:0]               memWord;
   logic [1:0]               lane;

   assign instrOffset = byteIndex - 8'd1;
   assign regOffset   = byteIndex - RegBase;
   assign memOffset   = byteIndex - MemBase;
   assign regWord     = regOffset >> 2;   // Four bytes per word
   assign memWord     = memOffset >> 2;

   ////////////////////////////////////////////////////////////////////////////
   // Segment and lane
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (byteIndex == 8'd0) begin
         segment = dumpFramePkg::SegPc;
      end else if (byteIndex < RegBase) begin
         segment = dumpFramePkg::SegInstr;
      end else if (byteIndex < MemBase) begin
         segment = dumpFramePkg::SegReg;
      end else begin
         segment = dumpFramePkg::SegMem;
      end
   end

   always_comb begin
      case (segment)
         dumpFramePkg::SegInstr: lane = instrOffset[1:0];
         dumpFramePkg::SegReg:   lane = regOffset[1:0];
         dumpFramePkg::SegMem:   lane = memOffset[1:0];
         default:                lane = 2'd0;   // PC is a single byte
      endcase
   end

   // Addresses point at word 0 outside their own segment
   assign debugRegAddr = (segment == dumpFramePkg::SegReg) ?
                         8'(regWord[RegAddrWidth-1:0]) : 8'd0;
   assign debugMemAddr = (segment == dumpFramePkg::SegMem) ?
                         8'(memWord[MemAddrWidth-1:0]) : 8'd0;

   ////////////////////////////////////////////////////////////////////////////
   // Output byte
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (segment)
         dumpFramePkg::SegPc:    dataToSend = fetchPc;
         dumpFramePkg::SegInstr: dataToSend = dumpFramePkg::wordByte(ifIdInstr, lane);
         dumpFramePkg::SegReg:   dataToSend = dumpFramePkg::wordByte(regData, lane);
         default:                dataToSend = dumpFramePkg::wordByte(memoryRamData, lane);
      endcase
   end

endmodule

// File: design/debugTop.sv
`timescale 1ns/1ps

module debugTop #(
   parameter int NumRegs     = 32,
   parameter int NumMemWords = 16
) (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  endOfProgram,
   input  dumpFramePkg::dumpByte uartFifoDataIn,
   input  logic                  uartDataAvailable,   // RX FIFO not empty
   input  logic                  uartDataSent,
   input  logic [7:0]            fetchPc,
   input  dumpFramePkg::dumpWord ifIdInstr,
   input  dumpFramePkg::dumpWord regData,
   input  dumpFramePkg::dumpWord memoryRamData,
   output logic                  nextFifoValue,
   output logic                  datapathOn,
   output logic                  datapathReset,
   output logic                  ledIdle,
   output logic                  debugRamSrc,         // Memory takes the debug address
   output logic [7:0]            debugRegAddr,
   output logic [7:0]            debugMemAddr,
   output dumpFramePkg::dumpByte dataToSend,
   output logic                  notStartUartTrans,
   output logic                  dumpDone
);

   logic [7:0] byteIndex;

   ////////////////////////////////////////////////////////////////////////////
   // Command handling
   ////////////////////////////////////////////////////////////////////////////

   debugCommandFsm commandFsm (
      .clock             (clock),
      .reset             (reset),
      .endOfProgram      (endOfProgram),
      .uartFifoDataIn    (uartFifoDataIn),
      .uartDataAvailable (uartDataAvailable),
      .dumpDone          (dumpDone),
      .nextFifoValue     (nextFifoValue),
      .datapathOn        (datapathOn),
      .datapathReset     (datapathReset),
      .ledIdle           (ledIdle),
      .dumpActive        (debugRamSrc)          // SEND state owns the memory port
   );

   ////////////////////////////////////////////////////////////////////////////
   // Dump path
   ////////////////////////////////////////////////////////////////////////////

   dumpSequencer #(
      .NumRegs     (NumRegs),
      .NumMemWords (NumMemWords)
   ) sequencer (
      .clock             (clock),
      .reset             (reset),
      .dumpActive        (debugRamSrc),
      .uartDataSent      (uartDataSent),
      .byteIndex         (byteIndex),
      .notStartUartTrans (notStartUartTrans),
      .dumpDone          (dumpDone)
   );

   dumpFrameMux #(
      .NumRegs     (NumRegs),
      .NumMemWords (NumMemWords)
   ) frameMux (
      .byteIndex     (byteIndex),
      .fetchPc       (fetchPc),
      .ifIdInstr     (ifIdInstr),
      .regData       (regData),
      .memoryRamData (memoryRamData),
      .debugRegAddr  (debugRegAddr),
      .debugMemAddr  (debugMemAddr),
      .dataToSend    (dataToSend)
   );

endmodule

// File: tb/debugTopProps.sv
`timescale 1ns/1ps

module debugTopProps (
   input logic clock,
   input logic reset,
   input logic uartDataAvailable,
   input logic nextFifoValue,
   input logic datapathOn,
   input logic datapathReset,
   input logic debugRamSrc,
   input logic notStartUartTrans
);

   popNeedsData: assert property (@(posedge clock) disable iff (reset)
      nextFifoValue |-> uartDataAvailable)
      else $error("RX FIFO popped with no byte waiting");

   // Pipeline cannot run while held in reset
   runOrReset: assert property (@(posedge clock) disable iff (reset)
      !(datapathOn && datapathReset))
      else $error("datapathOn and datapathReset high together");

   dumpStopsPipe: assert property (@(posedge clock) disable iff (reset)
      debugRamSrc |-> !datapathOn)
      else $error("Datapath running during a dump");

   txOnlyInDump: assert property (@(posedge clock) disable iff (reset)
      !notStartUartTrans |-> debugRamSrc)
      else $error("Transmitter enabled outside a dump");

endmodule

bind debugTop debugTopProps props (
   .clock             (clock),
   .reset             (reset),
   .uartDataAvailable (uartDataAvailable),
   .nextFifoValue     (nextFifoValue),
   .datapathOn        (datapathOn),
   .datapathReset     (datapathReset),
   .debugRamSrc       (debugRamSrc),
   .notStartUartTrans (notStartUartTrans)
);

// File: tb/debugTopTb.sv
`timescale 1ns/1ps

module debugTopTb;

   localparam int NumRegs     = 32;
   localparam int NumMemWords = 16;
   localparam int RegIdxBits  = $clog2(NumRegs);
   localparam int MemIdxBits  = $clog2(NumMemWords);
   localparam int WordBytes   = dumpFramePkg::WordBytes;
   localparam int FrameLen    = dumpFramePkg::frameBytes(NumRegs, NumMemWords);
   localparam int RegBase     = dumpFramePkg::HeaderBytes;   // First register byte
   localparam int MemBase     = RegBase + WordBytes * NumRegs;
   localparam int DumpCycles  = FrameLen * 6;                 // Slowest transmitter gap
   localparam int NumDumps    = 5;
   localparam int CycleLimit  = 3 * NumDumps * DumpCycles + 2000;

   logic                  clock;
   logic                  reset;
   logic                  endOfProgram;
   dumpFramePkg::dumpByte uartFifoDataIn;
   logic                  uartDataAvailable;
   logic                  uartDataSent = 1'b0;
   logic [7:0]            fetchPc      = 8'h40;
   dumpFramePkg::dumpWord ifIdInstr    = 32'h0000_0013;
   dumpFramePkg::dumpWord regData;
   dumpFramePkg::dumpWord memoryRamData;
   logic                  nextFifoValue;
   logic                  datapathOn;
   logic                  datapathReset;
   logic                  ledIdle;
   logic                  debugRamSrc;
   logic [7:0]            debugRegAddr;
   logic [7:0]            debugMemAddr;
   dumpFramePkg::dumpByte dataToSend;
   logic                  notStartUartTrans;
   logic                  dumpDone;

   dumpFramePkg::dumpWord regFile  [NumRegs];
   dumpFramePkg::dumpWord memWords [NumMemWords];
   logic                  stallTx;                   // Transmitter withholds the sent pulse
   int unsigned           gapLeft    = 1;
   int                    txIndex    = 0;
   int                    popCount   = 0;
   int                    runCycles  = 0;
   int                    doneCount  = 0;
   int                    cycleCount = 0;
   int                    errorCount = 0;
   int                    checkCount = 0;
   int                    testsRun   = 0;
   int                    testsFailed = 0;
   int                    testErrorStart;
   string                 currentTest = "setup";

   debugTop dut (.*);

   // Register file and memory answer in the same cycle
   assign regData       = regFile[debugRegAddr[RegIdxBits-1:0]];
   assign memoryRamData = memWords[debugMemAddr[MemIdxBits-1:0]];

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checking helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic compareByte(input string what, input dumpFramePkg::dumpByte expected,
                              input dumpFramePkg::dumpByte actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %s: %s expected 0x%h, actual 0x%h", currentTest, what, expected,
                  actual);
      end
   endtask

   task automatic compareFlag(input string what, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("[ERROR] %s: %s expected %b, actual %b", currentTest, what, expected, actual);
      end
   endtask

   // Frame layout: PC, IF/ID word, registers, then memory
   function automatic dumpFramePkg::dumpByte expectedFrameByte(input int index);
      dumpFramePkg::dumpWord word;
      int                    offset;
      if (index == 0) begin
         return fetchPc;
      end
      if (index < RegBase) begin
         word   = ifIdInstr;
         offset = index - 1;
      end else if (index < MemBase) begin
         word   = regFile[RegIdxBits'((index - RegBase) / WordBytes)];
         offset = index - RegBase;
      end else begin
         word   = memWords[MemIdxBits'((index - MemBase) / WordBytes)];
         offset = index - MemBase;
      end
      return 8'(word >> (8 * (WordBytes - 1 - offset % WordBytes)));   // MSB first
   endfunction

   task automatic checkFrameByte(input int index);
      compareByte($sformatf("byte %0d", index), expectedFrameByte(index), dataToSend);
      if (index >= RegBase && index < MemBase) begin
         compareByte("debugRegAddr", 8'((index - RegBase) / WordBytes), debugRegAddr);
      end
      if (index >= MemBase) begin
         compareByte("debugMemAddr", 8'((index - MemBase) / WordBytes), debugMemAddr);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Processor model, transmitter and event counters
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clock) begin
      if (reset) begin
         txIndex      <= 0;
         gapLeft      <= 1;
         uartDataSent <= 1'b0;
      end else begin
         if (nextFifoValue) begin
            popCount <= popCount + 1;
         end
         if (datapathOn) begin                    // Pipeline advances one clock
            runCycles <= runCycles + 1;
            fetchPc   <= fetchPc + 8'd4;
            ifIdInstr <= $urandom();
         end
         if (dumpDone) begin
            doneCount <= doneCount + 1;
            compareByte("frame length", 8'(FrameLen), 8'(txIndex));
            txIndex <= 0;
         end
         if (uartDataSent) begin                  // Byte leaves on this edge
            checkFrameByte(txIndex);
            txIndex      <= txIndex + 1;
            uartDataSent <= 1'b0;
            gapLeft      <= $urandom_range(4, 1);
         end else if (!notStartUartTrans && !stallTx) begin
            if (gapLeft <= 1) begin
               uartDataSent <= 1'b1;
            end else begin
               gapLeft <= gapLeft - 1;
            end
         end
      end
   end

   initial begin : watchdog
      while (cycleCount < CycleLimit) begin
         @(posedge clock);
         cycleCount++;
      end
      $display("Timeout after %0d cycles in %s, a dump never finished", CycleLimit,
               currentTest);
      $display("tests failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic applyReset();
      reset <= 1'b1;
      repeat (3) @(posedge clock);
      reset <= 1'b0;
   endtask

   // Holds the byte in the RX FIFO until the controller pops it
   task automatic sendCommand(input dumpFramePkg::dumpByte cmd);
      @(posedge clock);
      uartFifoDataIn    <= cmd;
      uartDataAvailable <= 1'b1;
      do begin
         @(posedge clock);
      end while (!nextFifoValue);
      uartDataAvailable <= 1'b0;
   endtask

   task automatic waitDumpDone();
      do begin
         @(posedge clock);
      end while (!dumpDone);
      @(posedge clock);                           // State after SEND is now visible
   endtask

   task automatic runStep();
      int runsBefore;
      int donesBefore;
      runsBefore  = runCycles;
      donesBefore = doneCount;
      sendCommand("n");
      @(posedge clock);                           // First cycle of SEND
      compareFlag("debugRamSrc in dump", 1'b1, debugRamSrc);
      waitDumpDone();
      compareFlag("debugRamSrc after dump", 1'b0, debugRamSrc);
      compareByte("datapathOn cycles", 8'd1, 8'(runCycles - runsBefore));
      compareByte("dumpDone pulses", 8'd1, 8'(doneCount - donesBefore));
   endtask

   task automatic startTest(input string name);
      currentTest    = name;
      testErrorStart = errorCount;
   endtask

   task automatic endTest();
      testsRun++;
      if (errorCount != testErrorStart) begin
         testsFailed++;
         $display("%-18s FAILED with %0d errors", currentTest, errorCount - testErrorStart);
      end else begin
         $display("%-18s ok", currentTest);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic resetState();
      startTest("resetState");
      applyReset();
      @(posedge clock);                           // INIT
      compareFlag("datapathOn", 1'b0, datapathOn);
      compareFlag("notStartUartTrans", 1'b1, notStartUartTrans);
      compareFlag("datapathReset", 1'b1, datapathReset);
      compareFlag("debugRamSrc", 1'b0, debugRamSrc);
      compareFlag("dumpDone", 1'b0, dumpDone);
      compareFlag("nextFifoValue", 1'b0, nextFifoValue);
      @(posedge clock);
      compareFlag("ledIdle", 1'b1, ledIdle);
      endTest();
   endtask

   task automatic unknownCommand();
      int popsBefore;
      startTest("unknownCommand");
      popsBefore = popCount;
      sendCommand("x");
      repeat (3) @(posedge clock);
      compareByte("pops", 8'd1, 8'(popCount - popsBefore));
      compareFlag("ledIdle", 1'b1, ledIdle);
      endTest();
   endtask

   task automatic stepDump();
      startTest("stepDump");
      sendCommand("s");
      @(posedge clock);
      compareFlag("ledIdle in step", 1'b0, ledIdle);
      runStep();
      compareFlag("ledIdle after first dump", 1'b0, ledIdle);
      runStep();
      compareFlag("ledIdle after second dump", 1'b0, ledIdle);
      endTest();
   endtask

   task automatic endInStep();
      startTest("endInStep");
      endOfProgram <= 1'b1;
      runStep();
      compareFlag("ledIdle", 1'b1, ledIdle);
      endOfProgram <= 1'b0;
      endTest();
   endtask

   task automatic continuousRun();
      int runsBefore;
      startTest("continuousRun");
      applyReset();
      runsBefore = runCycles;
      sendCommand("c");
      repeat (20) begin
         @(posedge clock);
         compareFlag("datapathOn while running", 1'b1, datapathOn);
      end
      endOfProgram <= 1'b1;
      waitDumpDone();
      compareByte("datapathOn cycles", 8'd21, 8'(runCycles - runsBefore));
      compareFlag("ledIdle", 1'b1, ledIdle);
      compareFlag("datapathOn after dump", 1'b0, datapathOn);
      endOfProgram <= 1'b0;
      runsBefore = runCycles;
      sendCommand("c");                           // Second run is refused
      repeat (4) @(posedge clock);
      compareByte("datapathOn cycles on second c", 8'd0, 8'(runCycles - runsBefore));
      compareFlag("ledIdle after second c", 1'b1, ledIdle);
      endTest();
   endtask

   task automatic transmitterStall();
      int                    donesBefore;
      dumpFramePkg::dumpByte held;
      startTest("transmitterStall");
      sendCommand("s");
      donesBefore = doneCount;
      sendCommand("n");
      do begin
         @(posedge clock);
      end while (txIndex < 60);
      stallTx <= 1'b1;
      repeat (2) @(posedge clock);                // Let a pulse in flight land
      held = dataToSend;
      repeat (50) begin
         @(posedge clock);
         compareByte("dataToSend during stall", held, dataToSend);
         compareFlag("notStartUartTrans during stall", 1'b0, notStartUartTrans);
         compareFlag("debugRamSrc during stall", 1'b1, debugRamSrc);
      end
      stallTx <= 1'b0;
      waitDumpDone();
      compareByte("dumpDone pulses", 8'd1, 8'(doneCount - donesBefore));
      endTest();
   endtask

   initial begin
      void'($urandom(59706));
      for (int i = 0; i < NumRegs; i++) begin
         regFile[RegIdxBits'(i)] = $urandom();
      end
      for (int i = 0; i < NumMemWords; i++) begin
         memWords[MemIdxBits'(i)] = $urandom();
      end
      reset             <= 1'b1;
      endOfProgram      <= 1'b0;
      uartFifoDataIn    <= 8'h00;
      uartDataAvailable <= 1'b0;
      stallTx           <= 1'b0;

      resetState();
      unknownCommand();
      stepDump();
      endInStep();
      continuousRun();
      transmitterStall();

      $display("%0d tests run, %0d failing, %0d checks, %0d errors", testsRun, testsFailed,
               checkCount, errorCount);
      if (errorCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: tb.f
design/debugCmdPkg.sv
design/dumpFramePkg.sv
design/debugCommandFsm.sv
design/dumpSequencer.sv
design/dumpFrameMux.sv
design/debugTop.sv
tb/debugTopProps.sv
tb/debugTopTb.sv

// File: Makefile
# Verilator build and run for the debug controller testbench

VERILATOR ?= verilator
TOP       ?= debugTopTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then \
	   echo "Simulation reported failure, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
